/* verilog/l1c_config.svh */
`ifndef L1C_CONFIG_SVH
`define L1C_CONFIG_SVH

// ##############################
// cache geometry
// ##############################

`define L1C_ADDR_W  32
`define L1C_DATA_W  32
`define L1C_OFS_W   4   // 16 bytes per line
`define L1C_IDX_W   6   // 64 lines
`define L1C_TAG_W   (`L1C_ADDR_W - `L1C_IDX_W - `L1C_OFS_W)
`define L1C_LINE_W  128

// ##############################
// bus
// ##############################

`define L1C_BEATS   4   // words per refill burst

`endif

/* verilog/l1c_pkg.sv */
`default_nettype none

`include "l1c_config.svh"

package l1c_pkg;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_CMP    = 3'd1,  // tag compare one cycle after acceptance
        ST_MREQ   = 3'd2,  // refill address phase
        ST_REFILL = 3'd3,
        ST_WRITE  = 3'd4,  // write-through store
        ST_READ   = 3'd5   // single-beat bypass read
    } l1c_state_e;

    typedef logic [`L1C_TAG_W-1:0]  l1c_tag_t;
    typedef logic [`L1C_LINE_W-1:0] l1c_line_t;

endpackage

`default_nettype wire

/* verilog/tag_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module tag_ram (
    input  wire                     clk,
    input  wire                     tag_cs,
    input  wire                     tag_we,
    input  wire [`L1C_IDX_W-1:0]    tag_addr,
    input  wire l1c_pkg::l1c_tag_t  tag_wdata,
    output l1c_pkg::l1c_tag_t       tag_rdata
);

    l1c_pkg::l1c_tag_t mem [0:(1 << `L1C_IDX_W)-1];

    // read data holds its value while the array is not selected
    always_ff @(posedge clk) begin
        if (tag_cs) begin
            if (tag_we) begin
                mem[tag_addr] <= tag_wdata;
            end else begin
                tag_rdata <= mem[tag_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module data_ram (
    input  wire                         clk,
    input  wire                         data_cs,
    input  wire                         data_we,
    input  wire [`L1C_IDX_W-1:0]        data_addr,
    input  wire [`L1C_LINE_W/8-1:0]     data_be,
    input  wire l1c_pkg::l1c_line_t     data_wdata,
    output l1c_pkg::l1c_line_t          data_rdata
);

    localparam int LINE_BYTES = `L1C_LINE_W / 8;

    l1c_pkg::l1c_line_t mem [0:(1 << `L1C_IDX_W)-1];

    // byte lanes let a refill beat or a store merge land in place
    always_ff @(posedge clk) begin
        if (data_cs) begin
            if (data_we) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (data_be[b]) begin
                        mem[data_addr][8*b +: 8] <= data_wdata[8*b +: 8];
                    end
                end
            end else begin
                data_rdata <= mem[data_addr];  // whole line, word picked in the controller
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/l1c.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module l1c (
    input  wire                         clk,
    input  wire                         rstn,
    // core side
    input  wire                         core_req,
    input  wire                         core_wr,
    input  wire                         core_bypass,
    input  wire                         core_flush,
    input  wire [`L1C_ADDR_W-1:0]       core_addr,
    input  wire [`L1C_DATA_W-1:0]       core_wdata,
    input  wire [`L1C_DATA_W/8-1:0]     core_byte,
    output logic [`L1C_DATA_W-1:0]      core_rdata,
    output logic                        core_err,
    output logic                        core_busy,
    // bus read channels
    output logic                        arvalid,
    input  wire                         arready,
    output logic [`L1C_ADDR_W-1:0]      araddr,
    output logic [7:0]                  arlen,
    input  wire                         rvalid,
    input  wire [`L1C_DATA_W-1:0]       rdata,
    input  wire                         rlast,
    input  wire                         rerr,
    // bus write channels
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`L1C_ADDR_W-1:0]      awaddr,
    output logic                        wvalid,
    input  wire                         wready,
    output logic [`L1C_DATA_W-1:0]      wdata,
    output logic [`L1C_DATA_W/8-1:0]    wstrb,
    input  wire                         bvalid,
    input  wire                         berr,
    // arrays
    output logic                        tag_cs,
    output logic                        tag_we,
    output logic [`L1C_IDX_W-1:0]       tag_addr,
    output l1c_pkg::l1c_tag_t           tag_wdata,
    input  wire l1c_pkg::l1c_tag_t      tag_rdata,
    output logic                        data_cs,
    output logic                        data_we,
    output logic [`L1C_IDX_W-1:0]       data_addr,
    output logic [`L1C_LINE_W/8-1:0]    data_be,
    output l1c_pkg::l1c_line_t          data_wdata,
    input  wire l1c_pkg::l1c_line_t     data_rdata
);

    localparam int WORD_BYTES = `L1C_DATA_W / 8;
    localparam int LINE_BYTES = `L1C_LINE_W / 8;
    localparam int BYTE_W     = $clog2(WORD_BYTES);
    localparam int WSEL_W     = $clog2(`L1C_BEATS);

    l1c_pkg::l1c_state_e           state_q;
    l1c_pkg::l1c_state_e           state_nxt;
    l1c_pkg::l1c_state_e           acc_state;

    logic [`L1C_ADDR_W-1:0]        addr_q;
    logic [`L1C_DATA_W-1:0]        wdata_q;
    logic [WORD_BYTES-1:0]         byte_q;
    logic [LINE_BYTES-1:0]         be_q;
    logic [`L1C_DATA_W-1:0]        rdata_q;
    logic [(1 << `L1C_IDX_W)-1:0]  valid_bits;
    logic                          valid_q;
    logic                          acc_q;
    logic                          err_q;
    logic [WSEL_W-1:0]             beat_cnt;
    logic [LINE_BYTES-1:0]         refill_mask;
    logic                          accept;
    logic                          hit;
    logic                          last_beat;
    logic [`L1C_IDX_W-1:0]         req_idx;
    logic [`L1C_IDX_W-1:0]         idx_q;
    logic [WSEL_W-1:0]             word_sel;

    assign req_idx   = core_addr[`L1C_OFS_W +: `L1C_IDX_W];
    assign idx_q     = addr_q[`L1C_OFS_W +: `L1C_IDX_W];
    assign word_sel  = addr_q[`L1C_OFS_W-1:BYTE_W];
    assign hit       = valid_q && (tag_rdata == addr_q[`L1C_ADDR_W-1 -: `L1C_TAG_W]);
    assign accept    = core_req && !core_busy;
    assign last_beat = rvalid && rlast;

    // ##############################
    // state machine
    // ##############################

    assign acc_state = core_wr     ? l1c_pkg::ST_WRITE :
                       core_bypass ? l1c_pkg::ST_READ  :
                                     l1c_pkg::ST_CMP;

    always_comb begin
        case (state_q)
            l1c_pkg::ST_IDLE: core_busy = 1'b0;
            l1c_pkg::ST_CMP:  core_busy = !hit;  // a hit frees the core at once
            default:          core_busy = 1'b1;
        endcase
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            l1c_pkg::ST_IDLE:   state_nxt = accept ? acc_state : l1c_pkg::ST_IDLE;
            l1c_pkg::ST_CMP: begin
                if (!hit) begin
                    state_nxt = l1c_pkg::ST_MREQ;
                end else begin
                    state_nxt = accept ? acc_state : l1c_pkg::ST_IDLE;
                end
            end
            l1c_pkg::ST_MREQ:   state_nxt = arready ? l1c_pkg::ST_REFILL : l1c_pkg::ST_MREQ;
            l1c_pkg::ST_REFILL: state_nxt = last_beat ? l1c_pkg::ST_IDLE : l1c_pkg::ST_REFILL;
            l1c_pkg::ST_WRITE:  state_nxt = bvalid ? l1c_pkg::ST_IDLE : l1c_pkg::ST_WRITE;
            l1c_pkg::ST_READ:   state_nxt = last_beat ? l1c_pkg::ST_IDLE : l1c_pkg::ST_READ;
            default:            state_nxt = l1c_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= l1c_pkg::ST_IDLE;
            acc_q   <= 1'b0;
        end else begin
            state_q <= state_nxt;
            acc_q   <= accept;  // marks the hit-check cycle of a store
        end
    end

    // ##############################
    // request latches
    // ##############################

    always_ff @(posedge clk) begin
        if (!core_busy) begin
            addr_q  <= core_addr;
            wdata_q <= core_wdata;
            byte_q  <= core_byte;
            be_q    <= {{(LINE_BYTES - WORD_BYTES){1'b0}}, core_byte}
                       << (core_addr[`L1C_OFS_W-1:BYTE_W] * WORD_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == l1c_pkg::ST_READ && rvalid) begin
            rdata_q <= rdata;
        end else if (state_q == l1c_pkg::ST_REFILL && rvalid && beat_cnt == word_sel) begin
            rdata_q <= rdata;  // the requested word out of the burst
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= valid_bits[req_idx] && !core_flush;  // a flush in the same cycle wins
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (core_flush) begin
            valid_bits <= '0;
        end else if (state_q == l1c_pkg::ST_REFILL && last_beat) begin
            valid_bits[idx_q] <= !(err_q || rerr);  // any bad beat leaves the line invalid
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            err_q <= 1'b0;
        end else if (accept) begin
            err_q <= 1'b0;
        end else if ((rvalid && rerr) || (bvalid && berr)) begin
            err_q <= 1'b1;
        end
    end

    // ##############################
    // refill beat tracking
    // ##############################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt    <= '0;
            refill_mask <= {{(LINE_BYTES - WORD_BYTES){1'b0}}, {WORD_BYTES{1'b1}}};
        end else if (state_q == l1c_pkg::ST_REFILL && rvalid) begin
            if (rlast) begin
                beat_cnt    <= '0;
                refill_mask <= {{(LINE_BYTES - WORD_BYTES){1'b0}}, {WORD_BYTES{1'b1}}};
            end else begin
                beat_cnt    <= beat_cnt + 1'b1;
                refill_mask <= {refill_mask[LINE_BYTES-WORD_BYTES-1:0],
                                refill_mask[LINE_BYTES-1 -: WORD_BYTES]};
            end
        end
    end

    // ##############################
    // bus channels
    // ##############################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            arvalid <= 1'b0;
        end else if ((accept && !core_wr && core_bypass) ||
                     (state_q == l1c_pkg::ST_CMP && !hit)) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    // aw and w go up together and drop on their own ready
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (accept && core_wr) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
        end
    end

    assign araddr = (state_q == l1c_pkg::ST_READ) ?
                    {addr_q[`L1C_ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}} :
                    {addr_q[`L1C_ADDR_W-1:`L1C_OFS_W], {`L1C_OFS_W{1'b0}}};
    assign arlen  = (state_q == l1c_pkg::ST_READ) ? 8'd0 : 8'(`L1C_BEATS - 1);
    assign awaddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = byte_q;

    // ##############################
    // array access
    // ##############################

    assign tag_addr  = core_busy ? idx_q : req_idx;
    assign data_addr = core_busy ? idx_q : req_idx;
    assign tag_wdata = addr_q[`L1C_ADDR_W-1 -: `L1C_TAG_W];

    always_comb begin
        tag_cs     = accept;  // tag and line are read while a request is taken
        tag_we     = 1'b0;
        data_cs    = accept;
        data_we    = 1'b0;
        data_be    = be_q;
        data_wdata = {`L1C_BEATS{wdata_q}};
        case (state_q)
            l1c_pkg::ST_REFILL: begin
                data_cs    = rvalid;
                data_we    = rvalid;
                data_be    = refill_mask;
                data_wdata = {`L1C_BEATS{rdata}};
                tag_cs     = last_beat;
                tag_we     = last_beat;
            end
            l1c_pkg::ST_WRITE: begin
                data_cs = acc_q && hit;  // store merge only on a hit
                data_we = acc_q && hit;
            end
            default: ;
        endcase
    end

    assign core_rdata = (state_q == l1c_pkg::ST_CMP) ?
                        data_rdata[word_sel*`L1C_DATA_W +: `L1C_DATA_W] : rdata_q;
    assign core_err   = err_q;

endmodule

`default_nettype wire

/* verilog/l1c_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module l1c_top (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         core_req,
    input  wire                         core_wr,
    input  wire                         core_bypass,
    input  wire                         core_flush,
    input  wire [`L1C_ADDR_W-1:0]       core_addr,
    input  wire [`L1C_DATA_W-1:0]       core_wdata,
    input  wire [`L1C_DATA_W/8-1:0]     core_byte,
    output logic [`L1C_DATA_W-1:0]      core_rdata,
    output logic                        core_err,
    output logic                        core_busy,
    output logic                        arvalid,
    input  wire                         arready,
    output logic [`L1C_ADDR_W-1:0]      araddr,
    output logic [7:0]                  arlen,
    input  wire                         rvalid,
    input  wire [`L1C_DATA_W-1:0]       rdata,
    input  wire                         rlast,
    input  wire                         rerr,
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`L1C_ADDR_W-1:0]      awaddr,
    output logic                        wvalid,
    input  wire                         wready,
    output logic [`L1C_DATA_W-1:0]      wdata,
    output logic [`L1C_DATA_W/8-1:0]    wstrb,
    input  wire                         bvalid,
    input  wire                         berr
);

    logic                          tag_cs;
    logic                          tag_we;
    logic [`L1C_IDX_W-1:0]         tag_addr;
    l1c_pkg::l1c_tag_t             tag_wdata;
    l1c_pkg::l1c_tag_t             tag_rdata;
    logic                          data_cs;
    logic                          data_we;
    logic [`L1C_IDX_W-1:0]         data_addr;
    logic [`L1C_LINE_W/8-1:0]      data_be;
    l1c_pkg::l1c_line_t            data_wdata;
    l1c_pkg::l1c_line_t            data_rdata;

    l1c u_ctrl (.*);

    tag_ram u_tag_ram (
        .clk       (clk),
        .tag_cs    (tag_cs),
        .tag_we    (tag_we),
        .tag_addr  (tag_addr),
        .tag_wdata (tag_wdata),
        .tag_rdata (tag_rdata)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .data_cs    (data_cs),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_be    (data_be),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] ERR_BASE = 32'h0000_3F00
) (
    input  wire         clk,
    input  wire         arvalid,
    output logic        arready,
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rerr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] awaddr,
    input  wire         wvalid,
    output logic        wready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    output logic        bvalid,
    output logic        berr
);

    localparam int MEM_BYTES = 16384;

    logic [7:0]  mem [0:MEM_BYTES-1];
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        rd_busy = 1'b0;
    logic        aw_got = 1'b0;
    logic        w_got = 1'b0;
    logic        b_pend = 1'b0;
    logic        b_bad = 1'b0;
    int          rd_left = 0;
    int          rd_gap = 0;
    int          b_gap = 0;

    function automatic logic in_window(input logic [31:0] a);
        return a[31:8] == ERR_BASE[31:8];
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    initial begin
        logic [31:0] a;
        for (int i = 0; i < MEM_BYTES; i++) begin
            a = i;
            mem[i] = 8'((a * 32'h9E37_79B1) >> 24);  // every address bit reaches the byte
        end
        {arready, rvalid, rdata, rlast, rerr} = '0;
        {awready, wready, bvalid, berr} = '0;
        forever begin
            @(posedge clk);
            // ##############################
            // handshakes seen at this edge
            // ##############################
            if (rvalid) begin
                if (rlast) begin
                    rd_busy = 1'b0;
                end else begin
                    rd_addr = rd_addr + 4;
                    rd_left = rd_left - 1;
                end
                rd_gap = $urandom % 4;
            end
            if (arvalid && arready) begin
                rd_busy = 1'b1;
                rd_addr = araddr;
                rd_left = arlen;
                rd_gap  = $urandom % 4;
            end
            if (bvalid) begin
                b_pend = 1'b0;
            end
            if (awvalid && awready) begin
                aw_got  = 1'b1;
                wr_addr = awaddr;
            end
            if (wvalid && wready) begin
                w_got   = 1'b1;
                wr_data = wdata;
                wr_strb = wstrb;
            end
            if (aw_got && w_got) begin
                b_bad = in_window(wr_addr);
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b] && !b_bad) begin
                        mem[{wr_addr[13:2], 2'b00} + b] = wr_data[8*b +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_pend = 1'b1;
                b_gap  = $urandom % 4;
            end
            #2;
            arready = !rd_busy && ($urandom % 2);
            awready = !aw_got && ($urandom % 2);
            wready  = !w_got && ($urandom % 2);
            if (rd_busy && rd_gap == 0) begin
                rvalid = 1'b1;
                rdata  = read_word(rd_addr);
                rlast  = (rd_left == 0);
                rerr   = in_window(rd_addr);
            end else begin
                {rvalid, rlast, rerr} = '0;
                if (rd_busy) rd_gap = rd_gap - 1;
            end
            if (b_pend && b_gap == 0) begin
                bvalid = 1'b1;
                berr   = b_bad;
            end else begin
                {bvalid, berr} = '0;
                if (b_pend) b_gap = b_gap - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/l1c_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module l1c_properties (
    input wire                          clk,
    input wire                          rstn,
    input wire                          core_busy,
    input wire                          arvalid,
    input wire                          arready,
    input wire [`L1C_ADDR_W-1:0]        araddr,
    input wire [7:0]                    arlen,
    input wire                          awvalid,
    input wire                          awready,
    input wire [`L1C_ADDR_W-1:0]        awaddr,
    input wire                          wvalid,
    input wire                          wready,
    input wire [`L1C_DATA_W-1:0]        wdata,
    input wire [`L1C_DATA_W/8-1:0]      wstrb,
    input wire                          rvalid,
    input wire                          rlast
);

    int unsigned prop_fails = 0;
    logic        burst_open;

    // open from the burst address handshake up to the beat with rlast
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            burst_open <= 1'b0;
        end else if (arvalid && arready && arlen != 8'd0) begin
            burst_open <= 1'b1;
        end else if (rvalid && rlast) begin
            burst_open <= 1'b0;
        end
    end

    // everything quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rstn |-> !core_busy && !arvalid && !awvalid && !wvalid)
        else begin prop_fails++; $error("outputs active during reset"); end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
        else begin prop_fails++; $error("read address dropped or changed before ready"); end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin prop_fails++; $error("write address dropped or changed before ready"); end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin prop_fails++; $error("write data dropped or changed before ready"); end

    aw_w_together: assert property (@(posedge clk) disable iff (!rstn)
        $rose(awvalid) |-> $rose(wvalid))
        else begin prop_fails++; $error("aw and w not raised together"); end

    refill_busy: assert property (@(posedge clk) disable iff (!rstn)
        burst_open |-> core_busy)
        else begin prop_fails++; $error("busy fell during refill before last beat"); end

endmodule

bind l1c l1c_properties u_props (.*);

`default_nettype wire

/* tests/l1c_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1c_config.svh"

module l1c_tb;

    localparam logic [31:0] ERR_BASE = 32'h0000_3F00;  // top 256 bytes of the 4 KB at 0x3000
    localparam int MEM_BYTES = 16384;

    logic clk;
    logic rstn;
    logic core_req, core_wr, core_bypass, core_flush;
    logic [31:0] core_addr, core_wdata, core_rdata, araddr, awaddr, wdata, rdata;
    logic [3:0] core_byte, wstrb;
    logic core_err, core_busy;
    logic arvalid, arready, rvalid, rlast, rerr;
    logic awvalid, awready, wvalid, wready, bvalid, berr;
    logic [7:0] arlen;

    logic [7:0] shadow [0:MEM_BYTES-1];
    logic [`L1C_TAG_W-1:0] exp_tag [0:63];
    logic [63:0] exp_valid = '0;  // lines the cache should be holding
    int unsigned val_errs = 0;
    int unsigned issued = 0;
    int unsigned cycles = 0;
    int unsigned ar_cnt = 0, aw_cnt = 0, w_cnt = 0;
    logic [31:0] ar_addr_seen, aw_addr_seen;
    logic [7:0]  ar_len_seen;
    logic [3:0]  w_strb_seen;
    logic [31:0] w_data_seen;

    l1c_top uut (.*);
    mem_model #(.ERR_BASE(ERR_BASE)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_cnt++;
            ar_addr_seen = araddr;
            ar_len_seen  = arlen;
        end
        if (awvalid && awready) begin
            aw_cnt++;
            aw_addr_seen = awaddr;
        end
        if (wvalid && wready) begin
            w_cnt++;
            w_strb_seen = wstrb;
            w_data_seen = wdata;
        end
        cycles++;
        if (cycles > 40 * issued + 200) begin
            $display("timeout after %0d cycles with %0d requests issued", cycles, issued);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic in_window(input logic [31:0] a);
        return a[31:8] == ERR_BASE[31:8];
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            val_errs++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // ##############################
    // core requests
    // ##############################

    task automatic load_word(input logic [31:0] addr, input logic bypass);
        int unsigned ar0;
        int waited;
        logic exp_hit;
        logic bad;
        logic [5:0] idx;
        idx     = addr[9:4];
        bad     = in_window(addr);
        exp_hit = !bypass && exp_valid[idx] && exp_tag[idx] == addr[31:10];
        ar0     = ar_cnt;
        waited  = 0;
        core_req = 1'b1;
        core_wr = 1'b0;
        core_bypass = bypass;
        core_addr = addr;
        issued++;
        @(posedge clk);
        #2;
        core_req = 1'b0;
        while (core_busy) begin
            @(posedge clk);
            #2;
            waited++;
        end
        check_value("core_err", bad, core_err);
        if (!bad) check_value("core_rdata", shadow_word(addr), core_rdata);
        if (exp_hit) begin
            check_value("ar count", ar0, ar_cnt);
            check_value("hit latency", 0, waited);
        end else begin
            check_value("ar count", ar0 + 1, ar_cnt);
            check_value("araddr", bypass ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0},
                        ar_addr_seen);
            check_value("arlen", bypass ? 0 : 3, ar_len_seen);
            if (!bypass) begin
                exp_valid[idx] = !bad;  // a failed refill also drops the old line
                exp_tag[idx]   = addr[31:10];
            end
        end
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        int unsigned ar0, aw0, w0;
        logic bad;
        ar0 = ar_cnt;
        aw0 = aw_cnt;
        w0  = w_cnt;
        bad = in_window(addr);
        core_req = 1'b1;
        core_wr = 1'b1;
        core_bypass = 1'b0;
        core_addr = addr;
        core_wdata = data;
        core_byte = be;
        issued++;
        @(posedge clk);
        #2;
        core_req = 1'b0;
        core_wr = 1'b0;
        while (core_busy) begin
            @(posedge clk);
            #2;
        end
        check_value("core_err", bad, core_err);
        check_value("aw count", aw0 + 1, aw_cnt);
        check_value("w count", w0 + 1, w_cnt);
        check_value("ar count", ar0, ar_cnt);
        check_value("awaddr", addr, aw_addr_seen);
        check_value("wstrb", be, w_strb_seen);
        check_value("wdata", data, w_data_seen);
        for (int b = 0; b < 4; b++) begin
            if (be[b] && !bad) shadow[{addr[13:2], 2'b00} + b] = data[8*b +: 8];
        end
    endtask

    task automatic flush_cache();
        core_flush = 1'b1;
        @(posedge clk);
        #2;
        core_flush = 1'b0;
        exp_valid = '0;
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(32'h769bffb3));
        for (int i = 0; i < MEM_BYTES; i++) begin
            a = i;
            shadow[i] = 8'((a * 32'h9E37_79B1) >> 24);
        end
        {core_req, core_wr, core_bypass, core_flush} = '0;
        core_addr = '0;
        core_wdata = '0;
        core_byte = '0;
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;
        load_word(32'h0000_0124, 1'b0);  // miss then hits in the same line
        load_word(32'h0000_0128, 1'b0);
        load_word(32'h0000_0120, 1'b0);
        repeat (40) begin
            a = ($urandom % 32'h1000) & 32'hFFFF_FFFC;
            store_word(a, $urandom, 4'($urandom_range(15, 1)));
            load_word(a, 1'b0);
            store_word(a, $urandom, 4'($urandom_range(15, 1)));  // lands on the line just cached
            load_word(a, 1'b0);
        end
        load_word(32'h0000_1804, 1'b1);  // bypass, then a real refill
        load_word(32'h0000_1808, 1'b0);
        flush_cache();
        load_word(32'h0000_180C, 1'b0);
        load_word(ERR_BASE + 32'h10, 1'b0);
        load_word(ERR_BASE + 32'h14, 1'b0);
        store_word(ERR_BASE + 32'h20, 32'hDEAD_BEEF, 4'hF);
        load_word(32'h0000_0124, 1'b0);
        repeat (200) begin
            a = ($urandom % 32'h1000) & 32'hFFFF_FFFC;
            case ($urandom % 8)
                4:       load_word(a, 1'b1);
                5, 6:    store_word(a, $urandom, 4'($urandom_range(15, 1)));
                7:       flush_cache();
                default: load_word(a, 1'b0);
            endcase
        end
        $display("errors: value %0d, properties %0d", val_errs, uut.u_ctrl.u_props.prop_fails);
        if (val_errs == 0 && uut.u_ctrl.u_props.prop_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/l1c_pkg.sv
verilog/tag_ram.sv
verilog/data_ram.sv
verilog/l1c.sv
verilog/l1c_top.sv
tests/mem_model.sv
tests/l1c_properties.sv
tests/l1c_tb.sv
